// File: include/decode_defs.svh
`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

// machine word width
`define M_WIDTH 32

// physical register specifier width
// architectural x0..x31 get zero-extended into this
`define LG_PRF_ENTRIES 6

// pattern history table index width
`define LG_PHT_SZ 8

// rv32i major opcodes, insn[6:0]
`define OPC_LOAD   7'h03
`define OPC_OP_IMM 7'h13
`define OPC_AUIPC  7'h17
`define OPC_STORE  7'h23
`define OPC_OP     7'h33
`define OPC_LUI    7'h37
`define OPC_BRANCH 7'h63
`define OPC_JALR   7'h67
`define OPC_JAL    7'h6f
`define OPC_SYSTEM 7'h73

`endif

// File: design/decode_pkg.sv
`include "decode_defs.svh"

package decode_pkg;

	// decoded operation
	// II is zero so a cleared uop reads as illegal
	typedef enum logic [5:0] {
		II,
		NOP,
		LB,
		LH,
		LW,
		LBU,
		LHU,
		SB,
		SH,
		SW,
		ADDI,
		SLLI,
		SLTI,
		XORI,
		SRLI,
		SRAI,
		ORI,
		ANDI,
		ADDU,
		SUBU,
		SLL,
		XOR,
		AUIPC,
		LUI,
		BEQ,
		BNE,
		BLT,
		BGE,
		BLTU,
		BGEU,
		JR,
		JALR,
		J,
		JAL,
		BREAK
	} op_t;

	// immediate layout selector
	typedef enum logic [2:0] {
		FMT_NONE,
		FMT_I,
		FMT_S,
		FMT_B,
		FMT_U,
		FMT_J
	} imm_fmt_t;

	// fetch side bundle, 105 bits
	typedef struct packed {
		logic [31:0]             insn;
		logic [`M_WIDTH-1:0]     pc;
		logic                    insn_pred;
		logic [`LG_PHT_SZ-1:0]   pht_idx;
		logic [`M_WIDTH-1:0]     pred_target;
	} fetch_t;

	// decoded micro-op handed to rename
	typedef struct packed {
		op_t                        op;
		logic [`LG_PRF_ENTRIES-1:0] srcA;
		logic [`LG_PRF_ENTRIES-1:0] srcB;
		logic [`LG_PRF_ENTRIES-1:0] dst;
		logic                       srcA_valid;
		logic                       srcB_valid;
		logic                       dst_valid;
		logic [15:0]                imm;
		logic [`M_WIDTH-17:0]       jmp_imm;
		logic [31:0]                rvimm;
		logic [`M_WIDTH-1:0]        pc;
		logic [`LG_PHT_SZ-1:0]      pht_idx;
		logic                       serializing_op;
		logic                       br_pred;
		logic                       is_br;
		logic                       is_mem;
		logic                       is_int;
		logic                       is_store;
	} uop_t;

endpackage

// File: design/stage_reg.sv
module stage_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     in_valid,
	input  payload_t in_data,
	output logic     out_valid,
	output payload_t out_data
);

	// valid just follows the upstream strobe
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			out_valid <= 1'b0;
		else
			out_valid <= in_valid;
	end

	// payload only moves on valid cycles
	// holds last value otherwise, keeps the datapath quiet
	// cleared so the stage reads all zero out of reset
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			out_data <= '0;
		else if (in_valid)
			out_data <= in_data;
	end

	// downstream consumes on valid with no stall, so an X here is fatal
	a_valid_known: assert property (@(posedge clk) disable iff (!arst_n)
		!$isunknown(out_valid))
		else $error("stage_reg: out_valid unknown");

endmodule

// File: design/decode_ctrl.sv
`include "decode_defs.svh"

module decode_ctrl (
	input  logic [31:0]          insn,
	output decode_pkg::op_t      op,
	output decode_pkg::imm_fmt_t fmt,
	output logic                 srcA_valid,
	output logic                 srcB_valid,
	output logic                 dst_valid,
	output logic                 is_mem,
	output logic                 is_int,
	output logic                 is_store,
	output logic                 is_br,
	output logic                 br_pred_static,
	output logic                 serializing
);
	import decode_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       rd_live;

	// writers to x0 collapse to a nop
	function automatic op_t wr_op(input op_t o, input logic live);
		wr_op = live ? o : NOP;
	endfunction

	assign opcode = insn[6:0];
	assign funct3 = insn[14:12];
	assign funct7 = insn[31:25];
	// rd field nonzero
	assign rd_live = (insn[11:7] != 5'd0);

	always_comb
	begin
		// default is illegal with nothing valid
		op = II;
		fmt = FMT_NONE;
		srcA_valid = 1'b0;
		srcB_valid = 1'b0;
		dst_valid = 1'b0;
		is_mem = 1'b0;
		is_int = 1'b0;
		is_store = 1'b0;
		is_br = 1'b0;
		br_pred_static = 1'b0;
		serializing = 1'b0;
		case (opcode)
		`OPC_LOAD:
		begin
			// srcA valid tracks the rd test here, not always set
			dst_valid = rd_live;
			srcA_valid = rd_live;
			is_mem = 1'b1;
			fmt = FMT_I;
			case (funct3)
			3'd0: op = wr_op(LB, rd_live);
			3'd1: op = wr_op(LH, rd_live);
			3'd2: op = wr_op(LW, rd_live);
			3'd4: op = wr_op(LBU, rd_live);
			3'd5: op = wr_op(LHU, rd_live);
			default: op = II;
			endcase
		end
		`OPC_OP_IMM:
		begin
			dst_valid = rd_live;
			srcA_valid = rd_live;
			is_int = 1'b1;
			fmt = FMT_I;
			case (funct3)
			3'd0: op = wr_op(ADDI, rd_live);
			3'd1: op = wr_op(SLLI, rd_live);
			3'd2: op = wr_op(SLTI, rd_live);
			// sltiu not supported, left illegal
			3'd3: op = II;
			3'd4: op = wr_op(XORI, rd_live);
			3'd5:
			begin
				// shift right, funct7 picks logical vs arith
				if (funct7 == 7'h00)
					op = wr_op(SRLI, rd_live);
				else if (funct7 == 7'h20)
					op = wr_op(SRAI, rd_live);
			end
			3'd6: op = wr_op(ORI, rd_live);
			default: op = wr_op(ANDI, rd_live);
			endcase
		end
		`OPC_STORE:
		begin
			srcA_valid = 1'b1;
			srcB_valid = 1'b1;
			is_mem = 1'b1;
			is_store = 1'b1;
			fmt = FMT_S;
			case (funct3)
			3'd0: op = SB;
			3'd1: op = SH;
			3'd2: op = SW;
			default: op = II;
			endcase
		end
		`OPC_OP:
		begin
			// only add/sub/sll/xor decoded
			dst_valid = rd_live;
			srcA_valid = 1'b1;
			srcB_valid = 1'b1;
			is_int = 1'b1;
			case ({funct7, funct3})
			{7'h00, 3'd0}: op = wr_op(ADDU, rd_live);
			{7'h20, 3'd0}: op = wr_op(SUBU, rd_live);
			{7'h00, 3'd1}: op = wr_op(SLL, rd_live);
			{7'h00, 3'd4}: op = wr_op(XOR, rd_live);
			default: op = II;
			endcase
		end
		`OPC_AUIPC, `OPC_LUI:
		begin
			op = wr_op((opcode == `OPC_LUI) ? LUI : AUIPC, rd_live);
			dst_valid = rd_live;
			is_int = 1'b1;
			fmt = FMT_U;
		end
		`OPC_BRANCH:
		begin
			// no static prediction on conditional branches
			srcA_valid = 1'b1;
			srcB_valid = 1'b1;
			is_int = 1'b1;
			fmt = FMT_B;
			case (funct3)
			3'd0: op = BEQ;
			3'd1: op = BNE;
			3'd4: op = BLT;
			3'd5: op = BGE;
			3'd6: op = BLTU;
			3'd7: op = BGEU;
			default: op = II;
			endcase
		end
		`OPC_JALR:
		begin
			// rd == x0 is a plain indirect jump
			op = rd_live ? JALR : JR;
			dst_valid = rd_live;
			srcA_valid = 1'b1;
			is_int = 1'b1;
			is_br = 1'b1;
			fmt = FMT_I;
		end
		`OPC_JAL:
		begin
			// direct target, always predicted taken
			op = rd_live ? JAL : J;
			dst_valid = rd_live;
			is_int = 1'b1;
			is_br = 1'b1;
			br_pred_static = 1'b1;
			fmt = FMT_J;
		end
		`OPC_SYSTEM:
		begin
			is_int = 1'b1;
			// ecall encoding treated as break, rest ignored
			if (insn[31:7] == 25'd0)
			begin
				op = BREAK;
				serializing = 1'b1;
			end
			else
				op = NOP;
		end
		default:
		begin
			op = II;
		end
		endcase
	end

	// rename stalls the machine on serializing, only break may ask for it
	always_comb
	begin
		if (serializing)
			a_ser_break: assert final (op == BREAK)
				else $error("decode_ctrl: serializing without BREAK");
	end

endmodule

// File: design/imm_gen.sv
module imm_gen (
	input  logic [31:0]          insn,
	input  decode_pkg::imm_fmt_t fmt,
	output logic [31:0]          rvimm
);
	import decode_pkg::*;

	// sign bit always lives in insn[31]
	logic sgn;

	assign sgn = insn[31];

	always_comb
	begin
		case (fmt)
		FMT_I:
		begin
			// loads, alu imm, jalr
			rvimm = {{20{sgn}}, insn[31:20]};
		end
		FMT_S:
		begin
			// offset split around rs2
			rvimm = {{20{sgn}}, insn[31:25], insn[11:7]};
		end
		FMT_B:
		begin
			// halfword offset, bit 11 parked in insn[7]
			rvimm = {{19{sgn}}, sgn, insn[7], insn[30:25], insn[11:8], 1'b0};
		end
		FMT_U:
		begin
			// upper 20, low 12 zero
			rvimm = {insn[31:12], 12'd0};
		end
		FMT_J:
		begin
			// jal scramble, 21-bit halfword offset
			rvimm = {{11{sgn}}, sgn, insn[19:12], insn[20], insn[30:21], 1'b0};
		end
		default:
		begin
			// register-register and system carry no immediate
			rvimm = 32'd0;
		end
		endcase
	end

endmodule

// File: design/uop_assemble.sv
`include "decode_defs.svh"

module uop_assemble (
	input  decode_pkg::fetch_t fetch,
	input  decode_pkg::op_t    op,
	input  logic [31:0]        rvimm,
	input  logic               srcA_valid,
	input  logic               srcB_valid,
	input  logic               dst_valid,
	input  logic               is_mem,
	input  logic               is_int,
	input  logic               is_store,
	input  logic               is_br,
	input  logic               br_pred_static,
	input  logic               serializing,
	output decode_pkg::uop_t   uop
);
	import decode_pkg::*;

	// zero pad from 5-bit arch reg to prf specifier
	localparam int ZP = `LG_PRF_ENTRIES - 5;

	logic [`LG_PRF_ENTRIES-1:0] rd;
	logic [`LG_PRF_ENTRIES-1:0] rs1;
	logic [`LG_PRF_ENTRIES-1:0] rs2;
	logic                       indirect;

	assign rd = {{ZP{1'b0}}, fetch.insn[11:7]};
	assign rs1 = {{ZP{1'b0}}, fetch.insn[19:15]};
	assign rs2 = {{ZP{1'b0}}, fetch.insn[24:20]};

	// jalr in either form, needs the predicted target
	assign indirect = (op == JR) || (op == JALR);

	always_comb
	begin
		uop = '0;
		uop.op = op;
		// specifiers only where the valid says so
		uop.srcA = srcA_valid ? rs1 : '0;
		uop.srcB = srcB_valid ? rs2 : '0;
		uop.dst = dst_valid ? rd : '0;
		uop.srcA_valid = srcA_valid;
		uop.srcB_valid = srcB_valid;
		uop.dst_valid = dst_valid;
		// predicted target split, low half in imm
		if (indirect)
		begin
			uop.imm = fetch.pred_target[15:0];
			uop.jmp_imm = fetch.pred_target[`M_WIDTH-1:16];
		end
		uop.rvimm = rvimm;
		// metadata straight from fetch
		uop.pc = fetch.pc;
		uop.pht_idx = fetch.pht_idx;
		uop.serializing_op = serializing;
		uop.br_pred = br_pred_static;
		uop.is_br = is_br;
		uop.is_mem = is_mem;
		uop.is_int = is_int;
		uop.is_store = is_store;
	end

	// a valid dst of x0 would allocate a prf entry for nothing
	// relies on the rd test in decode_ctrl
	always_comb
	begin
		if (uop.dst_valid)
			a_dst_nonzero: assert final (uop.dst != '0)
				else $error("uop_assemble: dst_valid with dst zero");
	end

endmodule

// File: design/decode_stage.sv
`include "decode_defs.svh"

module decode_stage (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  insn_valid,
	input  logic [31:0]           insn,
	input  logic [`M_WIDTH-1:0]   pc,
	input  logic                  insn_pred,
	input  logic [`LG_PHT_SZ-1:0] pht_idx,
	input  logic [`M_WIDTH-1:0]   pred_target,
	output logic                  uop_valid,
	output decode_pkg::uop_t      uop
);
	import decode_pkg::*;

	fetch_t   fetch_d;
	fetch_t   fetch_q;
	logic     fetch_valid;
	op_t      op;
	imm_fmt_t fmt;
	logic     srcA_valid;
	logic     srcB_valid;
	logic     dst_valid;
	logic     is_mem;
	logic     is_int;
	logic     is_store;
	logic     is_br;
	logic     br_pred_static;
	logic     serializing;
	logic [31:0] rvimm;
	uop_t     uop_d;

	// pack the loose fetch inputs
	assign fetch_d.insn = insn;
	assign fetch_d.pc = pc;
	assign fetch_d.insn_pred = insn_pred;
	assign fetch_d.pht_idx = pht_idx;
	assign fetch_d.pred_target = pred_target;

	// cycle 1, capture fetch bundle
	stage_reg #(.payload_t(fetch_t)) u_fetch_reg (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (insn_valid),
		.in_data   (fetch_d),
		.out_valid (fetch_valid),
		.out_data  (fetch_q)
	);

	decode_ctrl u_decode_ctrl (
		.insn           (fetch_q.insn),
		.op             (op),
		.fmt            (fmt),
		.srcA_valid     (srcA_valid),
		.srcB_valid     (srcB_valid),
		.dst_valid      (dst_valid),
		.is_mem         (is_mem),
		.is_int         (is_int),
		.is_store       (is_store),
		.is_br          (is_br),
		.br_pred_static (br_pred_static),
		.serializing    (serializing)
	);

	imm_gen u_imm_gen (
		.insn  (fetch_q.insn),
		.fmt   (fmt),
		.rvimm (rvimm)
	);

	uop_assemble u_uop_assemble (
		.fetch          (fetch_q),
		.op             (op),
		.rvimm          (rvimm),
		.srcA_valid     (srcA_valid),
		.srcB_valid     (srcB_valid),
		.dst_valid      (dst_valid),
		.is_mem         (is_mem),
		.is_int         (is_int),
		.is_store       (is_store),
		.is_br          (is_br),
		.br_pred_static (br_pred_static),
		.serializing    (serializing),
		.uop            (uop_d)
	);

	// cycle 2, register the uop
	stage_reg #(.payload_t(uop_t)) u_uop_reg (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (fetch_valid),
		.in_data   (uop_d),
		.out_valid (uop_valid),
		.out_data  (uop)
	);

endmodule

// File: sim/decode_tb_props.sv
`include "decode_defs.svh"

module decode_tb_props (
	input logic                  clk,
	input logic                  arst_n,
	input logic                  insn_valid,
	input logic [31:0]           insn,
	input logic [`M_WIDTH-1:0]   pc,
	input logic                  insn_pred,
	input logic [`LG_PHT_SZ-1:0] pht_idx,
	input logic [`M_WIDTH-1:0]   pred_target,
	input logic                  uop_valid,
	input decode_pkg::uop_t      uop
);
	timeunit 1ns;
	timeprecision 100ps;
	import decode_pkg::*;

	int     err_cnt;
	fetch_t in_f;
	// first shadow stage, lines up with u_fetch_reg
	fetch_t sh0_f;
	logic   sh0_v;
	// second stage, expected output, lines up with u_uop_reg
	logic   exp_valid;
	uop_t   exp_uop;
	logic   seen_any;

	initial err_cnt = 0;

	assign in_f = {insn, pc, insn_pred, pht_idx, pred_target};

	function automatic logic [31:0] sext(input logic [31:0] v, input int nbits);
		return 32'($signed(v << (32 - nbits)) >>> (32 - nbits));
	endfunction

	// expected micro-op, straight from the rv32i field rules
	function automatic uop_t model_uop(input fetch_t f);
		uop_t u;
		logic [31:0] w;
		logic [2:0] f3;
		logic [6:0] f7;
		logic wr;
		logic [`LG_PRF_ENTRIES-1:0] rd;
		logic [`LG_PRF_ENTRIES-1:0] rs1;
		logic [`LG_PRF_ENTRIES-1:0] rs2;
		w = f.insn;
		f3 = w[14:12];
		f7 = w[31:25];
		wr = (w[11:7] != 5'd0);
		rd = '0;
		rs1 = '0;
		rs2 = '0;
		rd[4:0] = w[11:7];
		rs1[4:0] = w[19:15];
		rs2[4:0] = w[24:20];
		u = '0;
		u.op = II;
		u.pc = f.pc;
		u.pht_idx = f.pht_idx;
		case (w[6:0])
		`OPC_LOAD:
		begin
			u.dst_valid = wr;
			// load srcA follows the rd test
			u.srcA_valid = wr;
			u.is_mem = 1'b1;
			u.rvimm = sext(32'(w[31:20]), 12);
			case (f3)
			3'd0: u.op = LB;
			3'd1: u.op = LH;
			3'd2: u.op = LW;
			3'd4: u.op = LBU;
			3'd5: u.op = LHU;
			default: u.op = II;
			endcase
			if (u.op != II && !wr)
				u.op = NOP;
		end
		`OPC_OP_IMM:
		begin
			u.dst_valid = wr;
			u.srcA_valid = wr;
			u.is_int = 1'b1;
			u.rvimm = sext(32'(w[31:20]), 12);
			case (f3)
			3'd0: u.op = ADDI;
			3'd1: u.op = SLLI;
			3'd2: u.op = SLTI;
			3'd4: u.op = XORI;
			3'd5: u.op = (f7 == 7'h00) ? SRLI : ((f7 == 7'h20) ? SRAI : II);
			3'd6: u.op = ORI;
			3'd7: u.op = ANDI;
			// funct3 3 stays illegal
			default: u.op = II;
			endcase
			if (u.op != II && !wr)
				u.op = NOP;
		end
		`OPC_STORE:
		begin
			u.srcA_valid = 1'b1;
			u.srcB_valid = 1'b1;
			u.is_mem = 1'b1;
			u.is_store = 1'b1;
			u.rvimm = sext(32'({w[31:25], w[11:7]}), 12);
			case (f3)
			3'd0: u.op = SB;
			3'd1: u.op = SH;
			3'd2: u.op = SW;
			default: u.op = II;
			endcase
		end
		`OPC_OP:
		begin
			u.dst_valid = wr;
			u.srcA_valid = 1'b1;
			u.srcB_valid = 1'b1;
			u.is_int = 1'b1;
			if (f7 == 7'h00 && f3 == 3'd0)
				u.op = ADDU;
			else if (f7 == 7'h20 && f3 == 3'd0)
				u.op = SUBU;
			else if (f7 == 7'h00 && f3 == 3'd1)
				u.op = SLL;
			else if (f7 == 7'h00 && f3 == 3'd4)
				u.op = XOR;
			if (u.op != II && !wr)
				u.op = NOP;
		end
		`OPC_AUIPC, `OPC_LUI:
		begin
			u.op = wr ? ((w[6:0] == `OPC_LUI) ? LUI : AUIPC) : NOP;
			u.dst_valid = wr;
			u.is_int = 1'b1;
			u.rvimm = {w[31:12], 12'd0};
		end
		`OPC_BRANCH:
		begin
			u.srcA_valid = 1'b1;
			u.srcB_valid = 1'b1;
			u.is_int = 1'b1;
			u.rvimm = sext(32'({w[31], w[7], w[30:25], w[11:8], 1'b0}), 13);
			case (f3)
			3'd0: u.op = BEQ;
			3'd1: u.op = BNE;
			3'd4: u.op = BLT;
			3'd5: u.op = BGE;
			3'd6: u.op = BLTU;
			3'd7: u.op = BGEU;
			default: u.op = II;
			endcase
		end
		`OPC_JALR:
		begin
			u.op = wr ? JALR : JR;
			u.dst_valid = wr;
			u.srcA_valid = 1'b1;
			u.is_int = 1'b1;
			u.is_br = 1'b1;
			u.rvimm = sext(32'(w[31:20]), 12);
			// predicted target rides in imm and jmp_imm
			u.imm = f.pred_target[15:0];
			u.jmp_imm = f.pred_target[`M_WIDTH-1:16];
		end
		`OPC_JAL:
		begin
			u.op = wr ? JAL : J;
			u.dst_valid = wr;
			u.is_int = 1'b1;
			u.is_br = 1'b1;
			u.br_pred = 1'b1;
			u.rvimm = sext(32'({w[31], w[19:12], w[20], w[30:21], 1'b0}), 21);
		end
		`OPC_SYSTEM:
		begin
			u.is_int = 1'b1;
			u.op = (w[31:7] == 25'd0) ? BREAK : NOP;
			u.serializing_op = (w[31:7] == 25'd0);
		end
		default:
		begin
			u.op = II;
		end
		endcase
		// specifiers only where valid
		u.srcA = u.srcA_valid ? rs1 : '0;
		u.srcB = u.srcB_valid ? rs2 : '0;
		u.dst = u.dst_valid ? rd : '0;
		return u;
	endfunction

	function automatic logic [20:0] reg_fields(input uop_t u);
		return {u.srcA, u.srcB, u.dst, u.srcA_valid, u.srcB_valid, u.dst_valid};
	endfunction

	function automatic logic [63:0] imm_fields(input uop_t u);
		return {u.imm, u.jmp_imm, u.rvimm};
	endfunction

	function automatic logic [5:0] flag_fields(input uop_t u);
		return {u.serializing_op, u.br_pred, u.is_br, u.is_mem, u.is_int, u.is_store};
	endfunction

	task automatic flag_error(input string msg);
		err_cnt++;
		$display("Error at time %0t: %s", $time, msg);
	endtask

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			sh0_v <= 1'b0;
			sh0_f <= '0;
			exp_valid <= 1'b0;
			exp_uop <= '0;
			seen_any <= 1'b0;
		end
		else
		begin
			sh0_v <= insn_valid;
			sh0_f <= in_f;
			exp_valid <= sh0_v;
			if (sh0_v)
			begin
				exp_uop <= model_uop(sh0_f);
				seen_any <= 1'b1;
			end
		end
	end

	// two cycle latency, nothing extra and nothing dropped
	a_valid: assert property (@(posedge clk) disable iff (!arst_n)
		uop_valid == exp_valid)
		else flag_error($sformatf("uop_valid %b, expected %b",
			$sampled(uop_valid), $sampled(exp_valid)));

	// register still clear until the first uop lands
	a_clear: assert property (@(posedge clk) disable iff (!arst_n)
		!seen_any |-> (uop == '0))
		else flag_error("uop not all zero after reset");

	a_meta: assert property (@(posedge clk) disable iff (!arst_n)
		exp_valid |-> (uop.pc == exp_uop.pc && uop.pht_idx == exp_uop.pht_idx))
		else flag_error($sformatf("pc/pht_idx %h/%h, expected %h/%h",
			$sampled(uop.pc), $sampled(uop.pht_idx),
			$sampled(exp_uop.pc), $sampled(exp_uop.pht_idx)));

	a_op: assert property (@(posedge clk) disable iff (!arst_n)
		exp_valid |-> (uop.op == exp_uop.op))
		else flag_error($sformatf("pc %h op %0d, expected %0d",
			$sampled(exp_uop.pc), $sampled(uop.op), $sampled(exp_uop.op)));

	a_regs: assert property (@(posedge clk) disable iff (!arst_n)
		exp_valid |-> (reg_fields(uop) == reg_fields(exp_uop)))
		else flag_error($sformatf("pc %h regs %h, expected %h", $sampled(exp_uop.pc),
			$sampled(reg_fields(uop)), $sampled(reg_fields(exp_uop))));

	a_imm: assert property (@(posedge clk) disable iff (!arst_n)
		exp_valid |-> (imm_fields(uop) == imm_fields(exp_uop)))
		else flag_error($sformatf("pc %h imm %h, expected %h", $sampled(exp_uop.pc),
			$sampled(imm_fields(uop)), $sampled(imm_fields(exp_uop))));

	a_flags: assert property (@(posedge clk) disable iff (!arst_n)
		exp_valid |-> (flag_fields(uop) == flag_fields(exp_uop)))
		else flag_error($sformatf("pc %h flags %b, expected %b", $sampled(exp_uop.pc),
			$sampled(flag_fields(uop)), $sampled(flag_fields(exp_uop))));

endmodule

// File: sim/decode_tb.sv
`include "decode_defs.svh"

module decode_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int PERIOD = 40;
	localparam int NUM_TESTS = 6;
	localparam int INSNS_PER_TEST = 40;
	// idle cycles to flush the two stage pipe at the end of a test
	localparam int DRAIN = 4;
	// each insn may take a gap cycle, plus reset and drain slack
	localparam int WATCHDOG_NS = (NUM_TESTS * INSNS_PER_TEST * 2 + 60) * PERIOD;

	logic                  clk;
	logic                  arst_n;
	logic                  insn_valid;
	logic [31:0]           insn;
	logic [`M_WIDTH-1:0]   pc;
	logic                  insn_pred;
	logic [`LG_PHT_SZ-1:0] pht_idx;
	logic [`M_WIDTH-1:0]   pred_target;
	logic                  uop_valid;
	decode_pkg::uop_t      uop;

	logic [15:0] lfsr;
	int          passed;
	int          failed;

	decode_stage u_dut (
		.clk         (clk),
		.arst_n      (arst_n),
		.insn_valid  (insn_valid),
		.insn        (insn),
		.pc          (pc),
		.insn_pred   (insn_pred),
		.pht_idx     (pht_idx),
		.pred_target (pred_target),
		.uop_valid   (uop_valid),
		.uop         (uop)
	);

	decode_tb_props u_props (
		.clk         (clk),
		.arst_n      (arst_n),
		.insn_valid  (insn_valid),
		.insn        (insn),
		.pc          (pc),
		.insn_pred   (insn_pred),
		.pht_idx     (pht_idx),
		.pred_target (pred_target),
		.uop_valid   (uop_valid),
		.uop         (uop)
	);

	initial clk = 1'b0;

	always #(PERIOD / 2) clk = ~clk;

	// 16-bit galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// one lfsr step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
		return r;
	endfunction

	function automatic logic [6:0] pick_opcode(input int t);
		logic [6:0] lst [0:7];
		logic [2:0] k;
		k = 3'(rand_bits(3));
		case (t)
		1: lst = '{`OPC_LOAD, `OPC_OP_IMM, `OPC_OP, `OPC_AUIPC,
			`OPC_LUI, `OPC_LOAD, `OPC_OP_IMM, `OPC_OP};
		2: lst = '{`OPC_LOAD, `OPC_OP_IMM, `OPC_JALR, `OPC_STORE,
			`OPC_BRANCH, `OPC_AUIPC, `OPC_LUI, `OPC_JAL};
		3: lst = '{`OPC_STORE, `OPC_BRANCH, `OPC_STORE, `OPC_BRANCH,
			`OPC_STORE, `OPC_BRANCH, `OPC_STORE, `OPC_BRANCH};
		4: lst = '{`OPC_JAL, `OPC_JALR, `OPC_JAL, `OPC_JALR,
			`OPC_JAL, `OPC_JALR, `OPC_JAL, `OPC_JALR};
		// system plus a few opcodes the decoder does not know
		5: lst = '{`OPC_SYSTEM, `OPC_SYSTEM, `OPC_SYSTEM, `OPC_SYSTEM,
			7'h0b, 7'h2b, 7'h57, 7'h7f};
		default: lst = '{`OPC_LOAD, `OPC_STORE, `OPC_OP, `OPC_BRANCH,
			`OPC_JAL, `OPC_JALR, `OPC_SYSTEM, 7'h7f};
		endcase
		return lst[k];
	endfunction

	function automatic logic [31:0] make_insn(input int t);
		logic [6:0]  opc;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [31:0] w;
		opc = pick_opcode(t);
		rd = 5'(rand_bits(5));
		// x0 destination about half the time in dest and jump tests
		if ((t == 1 || t == 4) && rand_bits(1) == 32'd1)
			rd = 5'd0;
		rs1 = 5'(rand_bits(5));
		rs2 = 5'(rand_bits(5));
		f3 = 3'(rand_bits(3));
		// lean funct7 toward 00 and 20 so the shift and add/sub forms show up
		if (rand_bits(1) == 32'd1)
			f7 = 7'(rand_bits(1)) << 5;
		else
			f7 = 7'(rand_bits(7));
		w = {f7, rs2, rs1, f3, rd, opc};
		// half the system words keep the all-zero break form
		if (opc == `OPC_SYSTEM && rand_bits(1) == 32'd1)
			w[31:7] = '0;
		return w;
	endfunction

	task automatic send_insn(input logic [31:0] w);
		@(posedge clk);
		#5;
		insn_valid = 1'b1;
		insn = w;
		pc = rand_bits(`M_WIDTH);
		insn_pred = 1'(rand_bits(1));
		pht_idx = `LG_PHT_SZ'(rand_bits(`LG_PHT_SZ));
		pred_target = rand_bits(`M_WIDTH);
	endtask

	task automatic idle_cycle;
		@(posedge clk);
		#5;
		insn_valid = 1'b0;
	endtask

	task automatic run_test(input int t, input string name);
		int errs_before;
		errs_before = u_props.err_cnt;
		for (int i = 0; i < INSNS_PER_TEST; i++)
		begin
			send_insn(make_insn(t));
			// occasional bubble, otherwise back to back
			if (rand_bits(2) == 32'd0)
				idle_cycle();
		end
		repeat (DRAIN) idle_cycle();
		if (u_props.err_cnt == errs_before)
		begin
			passed++;
			$display("test %0d %s: ok", t, name);
		end
		else
		begin
			failed++;
			$display("test %0d %s: %0d mismatches", t, name, u_props.err_cnt - errs_before);
		end
	endtask

	initial
	begin
		lfsr = 16'd63523;
		passed = 0;
		failed = 0;
		insn_valid = 1'b0;
		insn = '0;
		pc = '0;
		insn_pred = 1'b0;
		pht_idx = '0;
		pred_target = '0;
		arst_n = 1'b0;
		repeat (4) @(posedge clk);
		#5;
		arst_n = 1'b1;
		run_test(0, "latency_order");
		run_test(1, "dest_rule");
		run_test(2, "immediates");
		run_test(3, "sources_flags");
		run_test(4, "jumps");
		run_test(5, "system_illegal");
		$display("tests run %0d, passed %0d, failed %0d", NUM_TESTS, passed, failed);
		if (failed == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	// hard stop if the stimulus never gets through its tests
	initial
	begin
		#(WATCHDOG_NS);
		$display("run timed out after %0d ns before all tests finished", WATCHDOG_NS);
		$display("Test failed");
		$finish;
	end

endmodule

// File: tb.f
+incdir+include
design/decode_pkg.sv
design/stage_reg.sv
design/decode_ctrl.sv
design/imm_gen.sv
design/uop_assemble.sv
design/decode_stage.sv
sim/decode_tb_props.sv
sim/decode_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the decode stage testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --assert --top-module decode_tb -f tb.f \
	--Mdir obj_dir -o decode_tb_sim; then
	echo "verilator build failed"
	exit 1
fi

obj_dir/decode_tb_sim > "$log" 2>&1
status=$?
cat "$log"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test failed" "$log"; then
	exit 1
fi

if ! grep -q "Test passed" "$log"; then
	echo "no result line found in $log"
	exit 1
fi

exit 0
